/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_branch_unit -f flist.f
	@out="$$(./obj_dir/Vtb_branch_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --top-module tb_branch_unit -f flist.f
	verilator --lint-only --top-module branch_unit \
		hdl/br_pkg.sv hdl/br_decode.sv hdl/br_execute.sv hdl/br_result.sv hdl/branch_unit.sv

clean:
	rm -rf obj_dir

/* flist.f */
hdl/br_pkg.sv
hdl/br_decode.sv
hdl/br_execute.sv
hdl/br_result.sv
hdl/branch_unit.sv
tb/br_checker.sv
tb/tb_branch_unit.sv

/* hdl/br_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module br_decode (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             req_valid_i,
	input  br_pkg::br_req_t  req_i,
	output logic             dec_valid_o,
	output br_pkg::br_dec_t  dec_o
);

	import br_pkg::*;

	logic [5:0] opcode;
	br_kind_e   kind;
	cmp_kind_e  cmp;
	logic       link;
	br_dec_t    dec_next;

	assign opcode = req_i.inst[31:26];

	// ----------------------------------------
	// Opcode match
	// ----------------------------------------
	always_comb begin
		kind = BR_NONE;
		cmp  = CMP_EQ;
		link = 1'b0;
		case (opcode)
			OP_JIRL: kind = BR_IND;
			OP_B:    kind = BR_IMM;
			OP_BL: begin
				kind = BR_IMM;
				link = 1'b1;
			end
			OP_BEQ: begin
				kind = BR_COND;
				cmp  = CMP_EQ;
			end
			OP_BNE: begin
				kind = BR_COND;
				cmp  = CMP_NE;
			end
			OP_BLT: begin
				kind = BR_COND;
				cmp  = CMP_LT;
			end
			OP_BGE: begin
				kind = BR_COND;
				cmp  = CMP_GE;
			end
			OP_BLTU: begin
				kind = BR_COND;
				cmp  = CMP_LTU;
			end
			OP_BGEU: begin
				kind = BR_COND;
				cmp  = CMP_GEU;
			end
			default: ;
		endcase
	end

	// Field extraction, offs26 high part sits in inst[9:0]
	always_comb begin
		dec_next.pc       = req_i.pc;
		dec_next.rj_val   = req_i.rj_val;
		dec_next.rd_val   = req_i.rd_val;
		dec_next.pred_npc = req_i.pred_npc;
		dec_next.kind     = kind;
		dec_next.cmp      = cmp;
		dec_next.link     = link;
		dec_next.rj_idx   = req_i.inst[9:5];
		dec_next.rd_idx   = req_i.inst[4:0];
		dec_next.offs16   = req_i.inst[25:10];
		dec_next.offs26   = {req_i.inst[9:0], req_i.inst[25:10]};
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= req_valid_i;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			dec_o <= dec_next;
		end
	end

	a_dec_kind_known: assert property (
		@(posedge clk) disable iff (rst_i)
		dec_valid_o |-> !$isunknown(dec_o.kind)
	);

endmodule

`default_nettype wire

/* hdl/br_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module br_execute (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             dec_valid_i,
	input  br_pkg::br_dec_t  dec_i,
	output logic             exe_valid_o,
	output br_pkg::br_exe_t  exe_o
);

	import br_pkg::*;

	word_t     offs16_ext;
	word_t     offs26_ext;
	word_t     pc_plus4;
	word_t     target;
	word_t     actual_npc;
	logic      taken;
	logic      cmp_true;
	br_class_e cls;
	br_exe_t   exe_next;

	// Offsets sign extended and scaled to bytes
	assign offs16_ext = {{14{dec_i.offs16[15]}}, dec_i.offs16, 2'b00};
	assign offs26_ext = {{4{dec_i.offs26[25]}}, dec_i.offs26, 2'b00};
	assign pc_plus4   = dec_i.pc + 32'd4;

	// ----------------------------------------
	// Compare
	// ----------------------------------------
	always_comb begin
		case (dec_i.cmp)
			CMP_EQ:  cmp_true = dec_i.rj_val == dec_i.rd_val;
			CMP_NE:  cmp_true = dec_i.rj_val != dec_i.rd_val;
			CMP_LT:  cmp_true = $signed(dec_i.rj_val) < $signed(dec_i.rd_val);
			CMP_GE:  cmp_true = $signed(dec_i.rj_val) >= $signed(dec_i.rd_val);
			CMP_LTU: cmp_true = dec_i.rj_val < dec_i.rd_val;
			CMP_GEU: cmp_true = dec_i.rj_val >= dec_i.rd_val;
			default: cmp_true = 1'b0;
		endcase
	end

	// ----------------------------------------
	// Target and direction
	// ----------------------------------------
	always_comb begin
		case (dec_i.kind)
			BR_IMM: begin
				target = dec_i.pc + offs26_ext;
				taken  = 1'b1;
			end
			BR_IND: begin
				target = dec_i.rj_val + offs16_ext;
				taken  = 1'b1;
			end
			BR_COND: begin
				target = dec_i.pc + offs16_ext;
				taken  = cmp_true;
			end
			default: begin
				target = pc_plus4;
				taken  = 1'b0;
			end
		endcase
	end

	assign actual_npc = taken ? target : pc_plus4;

	// Call wins over return, e.g. jirl ra, ra, 0
	always_comb begin
		if (dec_i.link || (dec_i.kind == BR_IND && dec_i.rd_idx == RA_REG)) begin
			cls = CLS_CALL;
		end else if (dec_i.kind == BR_IND && dec_i.rj_idx == RA_REG &&
				dec_i.offs16 == 16'd0 && dec_i.rd_idx == 5'd0) begin
			cls = CLS_RET;
		end else if (dec_i.kind == BR_IMM || dec_i.kind == BR_IND) begin
			cls = CLS_ABS;
		end else begin
			cls = CLS_PC_REL;
		end
	end

	always_comb begin
		exe_next.pc         = dec_i.pc[31:2];
		exe_next.target     = target[31:2];
		exe_next.actual_npc = actual_npc[31:2];
		exe_next.pred_npc   = dec_i.pred_npc;
		exe_next.kind       = dec_i.kind;
		exe_next.taken      = taken;
		exe_next.cls        = cls;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			exe_valid_o <= 1'b0;
		end else begin
			exe_valid_o <= dec_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid_i) begin
			exe_o <= exe_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/br_pkg.sv */
`default_nettype none

package br_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	typedef logic [31:0] word_t;
	// Word-aligned PC, bits 31 to 2
	typedef logic [29:0] pc_word_t;
	typedef logic [4:0]  reg_idx_t;
	// Counter table index, PC bits 5 to 2
	typedef logic [3:0]  bht_idx_t;
	typedef logic [1:0]  ctr_t;

	localparam int       BHT_DEPTH = 16;
	// Weakly not taken
	localparam ctr_t     CTR_RESET = 2'b01;
	// Link register
	localparam reg_idx_t RA_REG    = 5'd1;

	// ----------------------------------------
	// Major opcodes, inst[31:26]
	// ----------------------------------------
	localparam logic [5:0] OP_JIRL = 6'h13;
	localparam logic [5:0] OP_B    = 6'h14;
	localparam logic [5:0] OP_BL   = 6'h15;
	localparam logic [5:0] OP_BEQ  = 6'h16;
	localparam logic [5:0] OP_BNE  = 6'h17;
	localparam logic [5:0] OP_BLT  = 6'h18;
	localparam logic [5:0] OP_BGE  = 6'h19;
	localparam logic [5:0] OP_BLTU = 6'h1a;
	localparam logic [5:0] OP_BGEU = 6'h1b;

	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_IMM  = 2'd1,
		BR_IND  = 2'd2,
		BR_COND = 2'd3
	} br_kind_e;

	typedef enum logic [2:0] {
		CMP_EQ  = 3'd0,
		CMP_NE  = 3'd1,
		CMP_LT  = 3'd2,
		CMP_GE  = 3'd3,
		CMP_LTU = 3'd4,
		CMP_GEU = 3'd5
	} cmp_kind_e;

	// Return stack hint
	typedef enum logic [1:0] {
		CLS_PC_REL = 2'd0,
		CLS_ABS    = 2'd1,
		CLS_CALL   = 2'd2,
		CLS_RET    = 2'd3
	} br_class_e;

	// ----------------------------------------
	// Stage records
	// ----------------------------------------
	typedef struct packed {
		word_t    pc;
		word_t    inst;
		word_t    rj_val;
		word_t    rd_val;
		pc_word_t pred_npc;
	} br_req_t;

	typedef struct packed {
		word_t       pc;
		word_t       rj_val;
		word_t       rd_val;
		pc_word_t    pred_npc;
		br_kind_e    kind;
		cmp_kind_e   cmp;
		logic        link;
		reg_idx_t    rj_idx;
		reg_idx_t    rd_idx;
		logic [15:0] offs16;
		logic [25:0] offs26;
	} br_dec_t;

	// Kind rides along so the result stage can drop non-branches
	typedef struct packed {
		pc_word_t  pc;
		pc_word_t  target;
		pc_word_t  actual_npc;
		pc_word_t  pred_npc;
		br_kind_e  kind;
		logic      taken;
		br_class_e cls;
	} br_exe_t;

	typedef struct packed {
		pc_word_t  pc;
		pc_word_t  target;
		logic      taken;
		br_class_e cls;
		logic      flush;
		ctr_t      ctr;
	} br_update_t;

endpackage

`default_nettype wire

/* hdl/br_result.sv */
`timescale 1ns/1ps
`default_nettype none

module br_result (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               exe_valid_i,
	input  br_pkg::br_exe_t    exe_i,
	output logic               upd_valid_o,
	output br_pkg::br_update_t upd_o
);

	import br_pkg::*;

	// Direction counter table
	ctr_t     bht_q [BHT_DEPTH];
	bht_idx_t idx;
	ctr_t     ctr_cur;
	ctr_t     ctr_next;
	logic     is_branch;
	logic     flush;

	assign is_branch = exe_valid_i && (exe_i.kind != BR_NONE);
	assign idx       = exe_i.pc[3:0];
	assign ctr_cur   = bht_q[idx];
	assign flush     = exe_i.pred_npc != exe_i.actual_npc;

	// ----------------------------------------
	// Saturating train
	// ----------------------------------------
	always_comb begin
		ctr_next = ctr_cur;
		if (exe_i.taken) begin
			if (ctr_cur != 2'b11) begin
				ctr_next = ctr_cur + 2'd1;
			end
		end else begin
			if (ctr_cur != 2'b00) begin
				ctr_next = ctr_cur - 2'd1;
			end
		end
	end

	// Read and write in the same cycle so back-to-back hits chain
	always_ff @(posedge clk) begin
		if (rst_i) begin
			upd_valid_o <= 1'b0;
			for (int i = 0; i < BHT_DEPTH; i++) begin
				bht_q[i] <= CTR_RESET;
			end
		end else begin
			upd_valid_o <= is_branch;
			if (is_branch) begin
				bht_q[idx] <= ctr_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (is_branch) begin
			upd_o.pc     <= exe_i.pc;
			upd_o.target <= exe_i.target;
			upd_o.taken  <= exe_i.taken;
			upd_o.cls    <= exe_i.cls;
			upd_o.flush  <= flush;
			upd_o.ctr    <= ctr_next;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	a_idle_after_reset: assert property (
		@(posedge clk) rst_i |=> !upd_valid_o
	);

	a_no_update_non_branch: assert property (
		@(posedge clk) disable iff (rst_i)
		(exe_valid_i && exe_i.kind == BR_NONE) |=> !upd_valid_o
	);

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               req_valid_i,
	input  br_pkg::br_req_t    req_i,
	output logic               upd_valid_o,
	output br_pkg::br_update_t upd_o
);

	import br_pkg::*;

	logic    dec_valid;
	br_dec_t dec;
	logic    exe_valid;
	br_exe_t exe;

	// Decode, one cycle
	br_decode u_br_decode (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.dec_valid_o (dec_valid),
		.dec_o       (dec)
	);

	// Compare and target, one cycle
	br_execute u_br_execute (
		.clk         (clk),
		.rst_i       (rst_i),
		.dec_valid_i (dec_valid),
		.dec_i       (dec),
		.exe_valid_o (exe_valid),
		.exe_o       (exe)
	);

	// Misprediction check and counter training
	br_result u_br_result (
		.clk         (clk),
		.rst_i       (rst_i),
		.exe_valid_i (exe_valid),
		.exe_i       (exe),
		.upd_valid_o (upd_valid_o),
		.upd_o       (upd_o)
	);

endmodule

`default_nettype wire

/* tb/br_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module br_checker (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               req_valid_i,
	input  logic               exp_branch_i,
	input  br_pkg::br_update_t exp_i,
	input  int                 exp_line_i,
	input  logic               upd_valid_i,
	input  br_pkg::br_update_t upd_i,
	output int                 error_count_o,
	output int                 pending_o,
	output int                 checked_o
);

	import br_pkg::*;

	br_update_t exp_q[$];
	int         line_q[$];
	ctr_t       model_q [BHT_DEPTH];
	int         errors = 0;
	int         checked = 0;

	assign error_count_o = errors;
	assign pending_o     = exp_q.size();
	assign checked_o     = checked;

	// 2-bit counter, saturating at both ends
	function automatic ctr_t saturate_counter(input ctr_t c, input logic taken);
		if (taken) begin
			return (c == 2'b11) ? c : c + 2'd1;
		end
		return (c == 2'b00) ? c : c - 2'd1;
	endfunction

	task automatic compare_field(input int line_no, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error line %0d %s: expected %h, actual %h",
				line_no, field, expected, actual);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Queue and compare
	// ----------------------------------------
	always @(posedge clk) begin
		br_update_t exp_rec;
		int         line_no;
		bht_idx_t   idx;
		if (rst_i) begin
			foreach (model_q[i]) begin
				model_q[i] = CTR_RESET;
			end
		end else begin
			// Pop before push so a stray update never meets a fresh entry
			if (upd_valid_i) begin
				if (exp_q.size() == 0) begin
					$display("Update for pc %h arrived with no branch outstanding",
						{upd_i.pc, 2'b00});
					errors++;
				end else begin
					exp_rec      = exp_q.pop_front();
					line_no      = line_q.pop_front();
					idx          = exp_rec.pc[3:0];
					model_q[idx] = saturate_counter(model_q[idx], exp_rec.taken);
					compare_field(line_no, "pc", {exp_rec.pc, 2'b00}, {upd_i.pc, 2'b00});
					compare_field(line_no, "target", {exp_rec.target, 2'b00},
						{upd_i.target, 2'b00});
					compare_field(line_no, "taken", 32'(exp_rec.taken), 32'(upd_i.taken));
					compare_field(line_no, "class", 32'(exp_rec.cls), 32'(upd_i.cls));
					compare_field(line_no, "flush", 32'(exp_rec.flush), 32'(upd_i.flush));
					compare_field(line_no, "ctr", 32'(model_q[idx]), 32'(upd_i.ctr));
					checked++;
				end
			end
			if (req_valid_i && exp_branch_i) begin
				exp_q.push_back(exp_i);
				line_q.push_back(exp_line_i);
			end
		end
	end

endmodule

`default_nettype wire

/* tb/branch_input.txt */
# pc inst rj_val rd_val pred_npc | is_branch taken target class flush, all hex
# class 0 pc_relative, 1 absolute, 2 call, 3 ret; fields after is_branch unused when it is 0
1c000000 58001085 00000005 00000005 1c000010 1 1 1c000010 0 0
1c000004 58001085 00000005 00000006 1c000014 1 0 1c000014 0 1
1c000008 5c001085 80000000 7fffffff 1c00000c 1 1 1c000018 0 1
1c00000c 5c001085 ffffffff ffffffff 1c000010 1 0 1c00001c 0 0
1c000010 60001085 80000000 00000001 1c000020 1 1 1c000020 0 0
1c000014 60001085 00000007 00000007 1c000018 1 0 1c000024 0 0
1c000018 64001085 fffffff0 fffffff0 1c00001c 1 1 1c000028 0 1
1c00001c 64001085 ffffffff 00000000 1c000020 1 0 1c00002c 0 0
1c000020 68001085 00000001 80000000 1c000030 1 1 1c000030 0 0
1c000024 68001085 80000000 80000000 1c000034 1 0 1c000034 0 1
1c000028 6c001085 ffffffff 00000001 1c000038 1 1 1c000038 0 0
1c00002c 6c001085 12345678 12345678 1c000030 1 1 1c00003c 0 1
1c000030 6c001085 00000001 00000002 1c000034 1 0 1c000040 0 0
1c000034 5bfff885 00000000 00000000 1c00002c 1 1 1c00002c 0 0
1c000038 028040a5 00000001 00000002 1c00003c 0 0 00000000 0 0
1c00003c 50010000 00000000 00000000 1c00013c 1 1 1c00013c 1 0
1c000040 508d1401 00000000 00000000 1c000044 1 1 1c048d54 1 1
1c000044 53fff3ff 00000000 00000000 1c000034 1 1 1c000034 1 0
1c000048 54040000 00000000 00000000 1c000448 1 1 1c000448 2 0
1c00004c 57ffc3ff 00000000 00000000 1c000050 1 1 1c00000c 2 1
1c000050 4c000181 1c002000 00000000 1c002000 1 1 1c002000 2 0
1c000054 4c000020 1c000050 00000000 1c000050 1 1 1c000050 3 0
1c000058 4c000820 1c001000 00000000 1c001000 1 1 1c001008 1 1
1c00005c 4ffffda0 1c003000 00000000 1c002ffc 1 1 1c002ffc 1 0
1c000060 4c000021 1c000400 00000000 1c000400 1 1 1c000400 2 0
1c000064 4c000022 1c000500 00000000 1c000068 1 1 1c000500 1 1
1c0000b8 5ffff885 00000001 00000002 1c0000b0 1 1 1c0000b0 0 0
1c0000b8 5ffff885 00000001 00000002 1c0000b0 1 1 1c0000b0 0 0
1c0000b8 5ffff885 00000001 00000002 1c0000b0 1 1 1c0000b0 0 0
1c0000b8 5ffff885 00000003 00000003 1c0000b0 1 0 1c0000b0 0 1
1c0000b8 5ffff885 00000003 00000003 1c0000bc 1 0 1c0000b0 0 0
1c0000b8 5ffff885 00000003 00000003 1c0000bc 1 0 1c0000b0 0 0
1c0000b8 5ffff885 00000003 00000003 1c0000bc 1 0 1c0000b0 0 0
1c0000bc 14000004 00000000 00000000 1c0000c0 0 0 00000000 0 0
1c0000c0 48000000 00000000 00000000 1c0000c4 0 0 00000000 0 0
1c0000c4 70000000 00000000 00000000 1c0000c8 0 0 00000000 0 0
1c0000c8 64001085 00000005 00000003 1c0000d8 1 1 1c0000d8 0 0
1c0000cc 60001085 00000001 80000000 1c0000d0 1 0 1c0000dc 0 0
1c0000d0 68001085 80000000 00000001 1c0000e0 1 0 1c0000e0 0 1

/* tb/tb_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;

	import br_pkg::*;

	logic       clk;
	logic       rst_i;
	logic       req_valid_i;
	br_req_t    req_i;
	logic       upd_valid_o;
	br_update_t upd_o;

	// Expected fields handed to the checker with each request
	logic       exp_branch;
	br_update_t exp_upd;
	int         exp_line;

	br_req_t    req_q[$];
	br_update_t exp_q[$];
	logic       branch_q[$];
	int         line_q[$];

	logic [31:0] lfsr;
	int          cycle_count = 0;
	int          cycle_limit;
	logic        loaded = 1'b0;
	int          tb_errors;
	int          check_errors;
	int          pending;
	int          checked;

	branch_unit u_branch_unit (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.upd_valid_o (upd_valid_o),
		.upd_o       (upd_o)
	);

	br_checker u_br_checker (
		.clk           (clk),
		.rst_i         (rst_i),
		.req_valid_i   (req_valid_i),
		.exp_branch_i  (exp_branch),
		.exp_i         (exp_upd),
		.exp_line_i    (exp_line),
		.upd_valid_i   (upd_valid_o),
		.upd_i         (upd_o),
		.error_count_o (check_errors),
		.pending_o     (pending),
		.checked_o     (checked)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	always @(posedge clk) begin
		if (loaded) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("Timeout after %0d cycles, %0d branch updates never arrived",
					cycle_limit, pending);
				$display("TESTBENCH FAILED");
				$finish;
			end
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_gap(output int gap);
		logic b0;
		logic b1;
		lfsr = lfsr_step(lfsr);
		b0   = lfsr[0];
		lfsr = lfsr_step(lfsr);
		b1   = lfsr[0];
		gap  = int'({b1, b0});
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [31:0] pc_v, inst_v, rj_v, rd_v, pred_v;
		logic [31:0] br_v, taken_v, target_v, cls_v, flush_v;
		br_req_t     req;
		br_update_t  exp_rec;
		fd = $fopen("tb/branch_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tb/branch_input.txt");
			tb_errors++;
			return;
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			line_no++;
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", pc_v, inst_v, rj_v, rd_v,
				pred_v, br_v, taken_v, target_v, cls_v, flush_v);
			if (n != 10) begin
				$display("Line %0d of the input file has %0d fields instead of 10", line_no, n);
				tb_errors++;
				continue;
			end
			req.pc          = pc_v;
			req.inst        = inst_v;
			req.rj_val      = rj_v;
			req.rd_val      = rd_v;
			req.pred_npc    = pred_v[31:2];
			exp_rec.pc      = pc_v[31:2];
			exp_rec.target  = target_v[31:2];
			exp_rec.taken   = taken_v[0];
			exp_rec.cls     = br_class_e'(cls_v[1:0]);
			exp_rec.flush   = flush_v[0];
			exp_rec.ctr     = '0;
			req_q.push_back(req);
			exp_q.push_back(exp_rec);
			branch_q.push_back(br_v[0]);
			line_q.push_back(line_no);
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int gap;
		int total;
		rst_i       = 1'b1;
		req_valid_i = 1'b0;
		req_i       = '0;
		exp_branch  = 1'b0;
		exp_upd     = '0;
		exp_line    = 0;
		lfsr        = 32'h6d98;
		tb_errors   = 0;
		load_vectors();
		// Worst case four cycles per line plus reset and pipeline drain
		cycle_limit = 4 * req_q.size() + 20;
		loaded      = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		for (int i = 0; i < req_q.size(); i++) begin
			next_gap(gap);
			// Branches that share a counter index go back to back
			if (i > 0 && branch_q[i] && branch_q[i - 1] &&
					req_q[i].pc[5:2] == req_q[i - 1].pc[5:2]) begin
				gap = 0;
			end
			repeat (gap) begin
				req_valid_i = 1'b0;
				exp_branch  = 1'b0;
				@(negedge clk);
			end
			req_valid_i = 1'b1;
			req_i       = req_q[i];
			exp_branch  = branch_q[i];
			exp_upd     = exp_q[i];
			exp_line    = line_q[i];
			@(negedge clk);
		end
		req_valid_i = 1'b0;
		exp_branch  = 1'b0;
		while (pending != 0) begin
			@(posedge clk);
		end
		// Three stages deep, so any stray update shows up by now
		repeat (4) @(posedge clk);
		total = tb_errors + check_errors;
		$display("Checked %0d updates from %0d lines, %0d errors", checked, req_q.size(), total);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
